/* logic/fe_params.svh */
// width, reset pc and memory depth macros for the fetch front end, included by rtl and testbench
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// program counter width
`define FE_PC_WD 64

// one rv64 instruction, no compressed forms
`define FE_INST_WD 32

// memory doubleword, two instructions per word
`define FE_MEM_DATA_WD 64

// log2 of depth in doublewords, 1024 x 8 bytes = 8 KiB
`define FE_MEM_AW 10

// first fetched pc
`define FE_PC_RESET 64'h0000_0000_8000_0000

// wishbone doubleword index width, same as the memory index
`define FE_WB_AW `FE_MEM_AW

`endif

/* logic/fe_pkg.sv */
// shared types for the fetch front end, referenced by scoped name from rtl and testbench
`include "fe_params.svh"

package fe_pkg;

  // program counter
  typedef logic [`FE_PC_WD-1:0] pc_t;

  // single instruction word
  typedef logic [`FE_INST_WD-1:0] inst_t;

  // one memory doubleword
  typedef logic [`FE_MEM_DATA_WD-1:0] mem_word_t;

  // doubleword index into the instruction memory
  typedef logic [`FE_MEM_AW-1:0] mem_addr_t;

  // redirect from decode back to fetch
  // taken only when the jal leaves decode
  typedef struct packed {
    logic taken;
    pc_t  target;
  } br_bus_t;

endpackage

/* logic/fe_stage_if.sv */
// fetch to decode stage link, one instance in the top level between the two stages
`timescale 1ns/1ns

interface fe_stage_if;

  // fetch side payload and valid
  logic          valid;
  fe_pkg::inst_t inst;
  fe_pkg::pc_t   pc;

  // decode can take a new instruction this cycle
  logic          allowin;

  // fetch drives payload, sees allowin
  modport fs (
    output valid,
    output inst,
    output pc,
    input  allowin
  );

  // decode consumes payload, drives allowin
  modport ds (
    input  valid,
    input  inst,
    input  pc,
    output allowin
  );

endinterface

/* logic/fe_imem.sv */
// instruction memory with a fetch read port and a wishbone classic slave port for the host
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_imem (
  input  logic              i_clk,
  input  logic              i_rst,
  // fetch read port
  input  logic              i_rd_en,
  input  fe_pkg::mem_addr_t i_rd_addr,
  output fe_pkg::mem_word_t o_rd_data,
  // wishbone classic slave
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  fe_pkg::mem_addr_t i_wb_adr,
  input  fe_pkg::mem_word_t i_wb_dat,
  output fe_pkg::mem_word_t o_wb_dat,
  output logic              o_wb_ack
);

  // storage array
  fe_pkg::mem_word_t mem [2**`FE_MEM_AW];

  // new wishbone request, blocked while ack is up so one strobe gives one ack
  logic wb_req;
  assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

  // ack pulse, one cycle after the request is seen
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
    end
  end

  // host side, write lands on the same edge that raises ack
  always_ff @(posedge i_clk) begin
    if (wb_req) begin
      if (i_wb_we) begin
        mem[i_wb_adr] <= i_wb_dat;
      end
      o_wb_dat <= mem[i_wb_adr];
    end
  end

  // fetch side, data held until the next enabled read
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

/* logic/fe_if_stage.sv */
// fetch stage, generates the pc, reads memory one cycle ahead and hands instructions to decode
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_if_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  // redirect from decode
  input  fe_pkg::br_bus_t   i_br_bus,
  // link to decode
  fe_stage_if.fs            to_ds,
  // memory read port
  output logic              o_rd_en,
  output fe_pkg::mem_addr_t o_rd_addr,
  input  fe_pkg::mem_word_t i_rd_data
);

  // pre-fetch request, always on once reset is released
  logic to_fs_valid;
  assign to_fs_valid = ~i_rst;

  // redirect fields
  logic        br_taken;
  fe_pkg::pc_t br_target;
  assign br_taken  = i_br_bus.taken;
  assign br_target = i_br_bus.target;

  // stage state
  logic        fs_valid;
  fe_pkg::pc_t fs_pc;
  logic        fs_allowin;

  // empty, or the held instruction moves on to decode
  assign fs_allowin = !fs_valid || to_ds.allowin;

  // load the next pc on a normal advance or on a redirect
  // a redirect overwrites whatever sits here, which drops the wrong-path fetch
  logic fs_load;
  assign fs_load = to_fs_valid && (fs_allowin || br_taken);

  // next pc select
  fe_pkg::pc_t seq_pc;
  fe_pkg::pc_t next_pc;
  assign seq_pc  = fs_pc + 64'd4;
  assign next_pc = br_taken ? br_target : seq_pc;

  // valid bit
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (fs_load) begin
      fs_valid <= to_fs_valid;
    end
  end

  // pc register
  // sits one word before the start so the first seq pc is the reset pc
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_pc <= `FE_PC_RESET - 64'd4;
    end else if (fs_load) begin
      fs_pc <= next_pc;
    end
  end

  // memory index, offset from the image base in doublewords
  fe_pkg::pc_t mem_offset;
  assign mem_offset = next_pc - `FE_PC_RESET;

  // read issued together with the pc load, so data and pc line up next cycle
  assign o_rd_en   = fs_load;
  assign o_rd_addr = mem_offset[`FE_MEM_AW+2:3];

  // half select
  // pc[2] clear takes the upper word, set takes the lower word
  fe_pkg::inst_t fs_inst;
  assign fs_inst = fs_pc[2] ? i_rd_data[31:0] : i_rd_data[63:32];

  // outputs to decode
  assign to_ds.valid = fs_valid;
  assign to_ds.inst  = fs_inst;
  assign to_ds.pc    = fs_pc;

endmodule

/* logic/fe_id_stage.sv */
// decode stage, finds jal, sends the redirect to fetch and presents instructions on the output
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_id_stage (
  input  logic            i_clk,
  input  logic            i_rst,
  // link from fetch
  fe_stage_if.ds          from_fs,
  // redirect to fetch
  output fe_pkg::br_bus_t o_br_bus,
  // output handshake
  output logic            o_out_valid,
  output fe_pkg::pc_t     o_out_pc,
  output fe_pkg::inst_t   o_out_inst,
  output logic            o_out_jump,
  input  logic            i_out_ready
);

  // jal major opcode
  localparam logic [6:0] OP_JAL = 7'b1101111;

  // stage state
  logic          ds_valid;
  fe_pkg::pc_t   ds_pc;
  fe_pkg::inst_t ds_inst;

  // output side handshake
  logic out_fire;
  assign out_fire = ds_valid && i_out_ready;

  // opcode check
  logic is_jal;
  assign is_jal = (ds_inst[6:0] == OP_JAL);

  // j-type immediate
  // imm[20|10:1|11|19:12] lives in inst[31:12], bit 0 is always zero
  fe_pkg::pc_t j_imm;
  assign j_imm = {{(`FE_PC_WD-20){ds_inst[31]}},
                  ds_inst[19:12],
                  ds_inst[20],
                  ds_inst[30:21],
                  1'b0};

  // jump target
  fe_pkg::pc_t jal_target;
  assign jal_target = ds_pc + j_imm;

  // redirect fires only as the jal leaves
  // a stalled jal keeps fetch waiting, no early redirect
  logic br_taken;
  assign br_taken = out_fire && is_jal;

  assign o_br_bus.taken  = br_taken;
  assign o_br_bus.target = jal_target;

  // take a new instruction when empty or when the current one leaves
  // refuse it when a jump leaves, fetch holds the wrong path then
  logic ds_allowin;
  assign ds_allowin      = (!ds_valid || out_fire) && !br_taken;
  assign from_fs.allowin = ds_allowin;

  // valid bit
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= from_fs.valid;
    end else if (br_taken) begin
      // jal gone, stage empty for the bubble cycle
      ds_valid <= 1'b0;
    end
  end

  // payload capture
  always_ff @(posedge i_clk) begin
    if (from_fs.valid && ds_allowin) begin
      ds_pc   <= from_fs.pc;
      ds_inst <= from_fs.inst;
    end
  end

  // output port, held steady by the stage registers while stalled
  assign o_out_valid = ds_valid;
  assign o_out_pc    = ds_pc;
  assign o_out_inst  = ds_inst;

  // jump flag rides along with the instruction
  assign o_out_jump  = is_jal;

endmodule

/* logic/fe_top.sv */
// fetch front end top level, memory plus fetch and decode stages behind plain ports
`timescale 1ns/1ns

module fe_top (
  input  logic              i_clk,
  input  logic              i_rst,
  // wishbone classic slave, host loads and reads program memory
  input  logic              i_wb_cyc,
  input  logic              i_wb_stb,
  input  logic              i_wb_we,
  input  fe_pkg::mem_addr_t i_wb_adr,
  input  fe_pkg::mem_word_t i_wb_dat,
  output fe_pkg::mem_word_t o_wb_dat,
  output logic              o_wb_ack,
  // decoded instruction stream
  output logic              o_out_valid,
  output fe_pkg::pc_t       o_out_pc,
  output fe_pkg::inst_t     o_out_inst,
  output logic              o_out_jump,
  input  logic              i_out_ready
);

  // fetch to decode link
  fe_stage_if u_fs_ds ();

  // redirect path, decode back to fetch
  fe_pkg::br_bus_t br_bus;

  // fetch read port wires
  logic              rd_en;
  fe_pkg::mem_addr_t rd_addr;
  fe_pkg::mem_word_t rd_data;

  fe_imem u_imem (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack)
  );

  fe_if_stage u_if_stage (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_br_bus  (br_bus),
    .to_ds     (u_fs_ds.fs),
    .o_rd_en   (rd_en),
    .o_rd_addr (rd_addr),
    .i_rd_data (rd_data)
  );

  fe_id_stage u_id_stage (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .from_fs     (u_fs_ds.ds),
    .o_br_bus    (br_bus),
    .o_out_valid (o_out_valid),
    .o_out_pc    (o_out_pc),
    .o_out_inst  (o_out_inst),
    .o_out_jump  (o_out_jump),
    .i_out_ready (i_out_ready)
  );

endmodule

/* dv/fe_tb.sv */
// testbench for the fetch front end, loads programs over wishbone and checks the output stream
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_tb;

  // image size in doublewords, reference depth and wait limits in cycles
  localparam int IMG_N      = 32;
  localparam int MAX_STEPS  = 64;
  localparam int WB_MAX     = 20;
  localparam int STREAM_MAX = 2000;

  // dut ports
  logic              i_clk;
  logic              i_rst;
  logic              i_wb_cyc;
  logic              i_wb_stb;
  logic              i_wb_we;
  fe_pkg::mem_addr_t i_wb_adr;
  fe_pkg::mem_word_t i_wb_dat;
  fe_pkg::mem_word_t o_wb_dat;
  logic              o_wb_ack;
  logic              o_out_valid;
  fe_pkg::pc_t       o_out_pc;
  fe_pkg::inst_t     o_out_inst;
  logic              o_out_jump;
  logic              i_out_ready;

  fe_top DUT (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_out_valid (o_out_valid),
    .o_out_pc    (o_out_pc),
    .o_out_inst  (o_out_inst),
    .o_out_jump  (o_out_jump),
    .i_out_ready (i_out_ready)
  );

  // 100 ns clock
  always #50 i_clk = ~i_clk;

  // program image and expected stream
  fe_pkg::mem_word_t img      [IMG_N];
  fe_pkg::pc_t       exp_pc   [MAX_STEPS];
  fe_pkg::inst_t     exp_inst [MAX_STEPS];
  logic              exp_jump [MAX_STEPS];
  int                exp_n;
  logic              chk_en;

  // owned by the checking process
  int            exp_idx;
  int            chk_err;
  int            stall_cnt;
  logic          hold_pending;
  fe_pkg::pc_t   held_pc;
  fe_pkg::inst_t held_inst;
  logic          held_jump;

  // owned by the stimulus process
  int          drv_err;
  int          n_tests;
  int          n_pass;
  logic [31:0] rng;

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // random non-jump instruction, op-imm opcode
  function automatic fe_pkg::inst_t random_alu_inst();
    logic [31:0] r;
    r = next_rand();
    return {r[31:7], 7'b0010011};
  endfunction

  // jal x1 with a byte offset
  function automatic fe_pkg::inst_t encode_jal(input int off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
  endfunction

  // sign-extended j-immediate of a jal
  function automatic fe_pkg::pc_t jal_offset(input fe_pkg::inst_t inst);
    return {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  // even slot is the upper half of its doubleword
  function automatic void set_slot(input int k, input fe_pkg::inst_t inst);
    if (k % 2 == 0) begin
      img[k / 2][63:32] = inst;
    end else begin
      img[k / 2][31:0] = inst;
    end
  endfunction

  function automatic void fill_straight();
    for (int k = 0; k < 2 * IMG_N; k++) begin
      set_slot(k, random_alu_inst());
    end
  endfunction

  // jumps forward, jal onto jal, and a backward loop over both halves
  function automatic void build_jump_image();
    fill_straight();
    set_slot(2, encode_jal(24));
    set_slot(9, encode_jal(16));
    set_slot(13, encode_jal(16));
    set_slot(18, encode_jal(-56));
  endfunction

  // reference walk over the image from the reset pc
  function automatic void ref_walk(input int n);
    fe_pkg::pc_t       pc;
    fe_pkg::pc_t       off;
    fe_pkg::mem_word_t dw;
    fe_pkg::inst_t     inst;
    int                idx;
    pc = `FE_PC_RESET;
    for (int k = 0; k < n; k++) begin
      off = pc - `FE_PC_RESET;
      idx = int'(off >> 3);
      dw = (idx < IMG_N) ? img[idx] : '0;
      inst = pc[2] ? dw[31:0] : dw[63:32];
      exp_pc[k]   = pc;
      exp_inst[k] = inst;
      exp_jump[k] = (inst[6:0] == 7'b1101111);
      pc = exp_jump[k] ? pc + jal_offset(inst) : pc + 64'd4;
    end
    exp_n = n;
  endfunction

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // one classic cycle, waits for ack, expects it one cycle wide
  task automatic wb_cycle(input logic we, input fe_pkg::mem_addr_t adr,
                          input fe_pkg::mem_word_t dat, output fe_pkg::mem_word_t rdat);
    int waited;
    @(negedge i_clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = dat;
    waited = 0;
    do begin
      @(negedge i_clk);
      waited++;
      if (waited > WB_MAX) begin
        abort_run("no wishbone ack");
      end
    end while (!o_wb_ack);
    if (waited != 1) begin
      $display("[FAIL] o_wb_ack latency expected %h got %h", 1, waited);
      drv_err++;
    end
    rdat = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    @(negedge i_clk);
    if (o_wb_ack !== 1'b0) begin
      $display("[FAIL] o_wb_ack second cycle expected %h got %h", 1'b0, o_wb_ack);
      drv_err++;
    end
  endtask

  // core keeps running meanwhile, a reset follows before any check
  task automatic load_image();
    fe_pkg::mem_word_t unused;
    chk_en = 1'b0;
    i_out_ready = 1'b0;
    for (int i = 0; i < IMG_N; i++) begin
      wb_cycle(1'b1, fe_pkg::mem_addr_t'(i), img[i], unused);
    end
  endtask

  task automatic reset_and_release();
    @(negedge i_clk);
    i_rst = 1'b1;
    repeat (3) @(negedge i_clk);
    i_rst = 1'b0;
  endtask

  // runs until target outputs were checked, notes the first valid cycle
  task automatic drain_stream(input int target, input bit rand_ready, output int first_cyc);
    int          cyc;
    logic [31:0] r;
    cyc = 0;
    first_cyc = -1;
    while (exp_idx < target) begin
      r = next_rand();
      i_out_ready = rand_ready ? r[3] : 1'b1;
      @(negedge i_clk);
      cyc++;
      if (first_cyc < 0 && o_out_valid) begin
        first_cyc = cyc;
      end
      if (cyc > STREAM_MAX) begin
        abort_run("output stream stopped");
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = drv_err + chk_err - errs_before;
    n_tests++;
    if (errs == 0) begin
      n_pass++;
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  // compares each output transfer with the next reference step
  always @(posedge i_clk) begin
    if (i_rst) begin
      exp_idx = 0;
      hold_pending = 1'b0;
    end else if (chk_en) begin
      // stalled output must stay put
      if (hold_pending && !o_out_valid) begin
        $display("o_out_valid dropped while the output was stalled");
        chk_err++;
      end else if (hold_pending && (o_out_pc !== held_pc || o_out_inst !== held_inst ||
                                    o_out_jump !== held_jump)) begin
        $display("[FAIL] o_out_pc/o_out_inst/o_out_jump moved in stall, pc %h -> %h, %s",
                 held_pc, o_out_pc, "see inst and jump");
        $display("[FAIL] o_out_inst %h -> %h, o_out_jump %h -> %h",
                 held_inst, o_out_inst, held_jump, o_out_jump);
        chk_err++;
      end
      if (o_out_valid && i_out_ready && exp_idx < exp_n) begin
        if (o_out_pc !== exp_pc[exp_idx]) begin
          $display("[FAIL] o_out_pc step %0d expected %h got %h",
                   exp_idx, exp_pc[exp_idx], o_out_pc);
          chk_err++;
        end
        if (o_out_inst !== exp_inst[exp_idx]) begin
          $display("[FAIL] o_out_inst step %0d expected %h got %h",
                   exp_idx, exp_inst[exp_idx], o_out_inst);
          chk_err++;
        end
        if (o_out_jump !== exp_jump[exp_idx]) begin
          $display("[FAIL] o_out_jump step %0d expected %h got %h",
                   exp_idx, exp_jump[exp_idx], o_out_jump);
          chk_err++;
        end
        exp_idx++;
      end
      if (o_out_valid && !i_out_ready) begin
        stall_cnt++;
      end
      hold_pending = o_out_valid && !i_out_ready;
      held_pc   = o_out_pc;
      held_inst = o_out_inst;
      held_jump = o_out_jump;
    end else begin
      hold_pending = 1'b0;
    end
  end

  initial begin
    int                base;
    int                first_cyc;
    int                stalls_before;
    fe_pkg::mem_word_t wr_data [8];
    fe_pkg::mem_word_t rd_data;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    i_out_ready = 1'b0;
    chk_en      = 1'b0;
    exp_n       = 0;
    drv_err     = 0;
    chk_err     = 0;
    stall_cnt   = 0;
    n_tests     = 0;
    n_pass      = 0;
    rng         = 32'hcd94;
    repeat (3) @(negedge i_clk);
    i_rst = 1'b0;

    // wishbone write then read back, upper half of memory
    base = drv_err + chk_err;
    for (int i = 0; i < 8; i++) begin
      wr_data[i] = {next_rand(), next_rand()};
      wb_cycle(1'b1, fe_pkg::mem_addr_t'(512 + 3 * i), wr_data[i], rd_data);
    end
    for (int i = 0; i < 8; i++) begin
      wb_cycle(1'b0, fe_pkg::mem_addr_t'(512 + 3 * i), '0, rd_data);
      if (rd_data !== wr_data[i]) begin
        $display("[FAIL] o_wb_dat expected %h got %h", wr_data[i], rd_data);
        drv_err++;
      end
    end
    finish_test("wishbone", base);

    // straight line, both halves, first valid two cycles after release
    base = drv_err + chk_err;
    fill_straight();
    load_image();
    ref_walk(64);
    reset_and_release();
    chk_en = 1'b1;
    drain_stream(64, 1'b0, first_cyc);
    chk_en = 1'b0;
    if (first_cyc != 2) begin
      $display("[FAIL] o_out_valid latency expected %h got %h", 2, first_cyc);
      drv_err++;
    end
    finish_test("straight", base);

    // forward and backward jal
    base = drv_err + chk_err;
    build_jump_image();
    load_image();
    ref_walk(40);
    reset_and_release();
    chk_en = 1'b1;
    drain_stream(40, 1'b0, first_cyc);
    chk_en = 1'b0;
    finish_test("jal", base);

    // random back-pressure
    base = drv_err + chk_err;
    stalls_before = stall_cnt;
    build_jump_image();
    load_image();
    ref_walk(60);
    reset_and_release();
    chk_en = 1'b1;
    drain_stream(60, 1'b1, first_cyc);
    chk_en = 1'b0;
    if (stall_cnt == stalls_before) begin
      $display("random ready never stalled the output");
      drv_err++;
    end
    finish_test("backpressure", base);

    // reset in the middle of a run
    base = drv_err + chk_err;
    fill_straight();
    load_image();
    ref_walk(24);
    reset_and_release();
    chk_en = 1'b1;
    drain_stream(10, 1'b1, first_cyc);
    i_rst = 1'b1;
    @(negedge i_clk);
    if (o_out_valid !== 1'b0) begin
      $display("[FAIL] o_out_valid in reset expected %h got %h", 1'b0, o_out_valid);
      drv_err++;
    end
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    drain_stream(24, 1'b1, first_cyc);
    chk_en = 1'b0;
    if (first_cyc != 2) begin
      $display("[FAIL] o_out_valid restart latency expected %h got %h", 2, first_cyc);
      drv_err++;
    end
    finish_test("midrun_reset", base);

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_pass, n_tests - n_pass, drv_err + chk_err);
    if (drv_err + chk_err == 0 && n_pass == n_tests) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+logic
logic/fe_pkg.sv
logic/fe_stage_if.sv
logic/fe_imem.sv
logic/fe_if_stage.sv
logic/fe_id_stage.sv
logic/fe_top.sv
dv/fe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the fetch front end testbench with verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -j 0 -f tb.f --top-module fe_tb -Mdir "$BUILD_DIR" -o fe_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fe_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi
